//--- u1plus_ctrl_pkg.sv
/*
 * u1plus control plane shared definitions
 * bus widths, request/response structs, address map and constants
 */
package u1plus_ctrl_pkg;

   localparam int WB_AW  = 11;        // master address width
   localparam int WB_DW  = 16;        // master data width
   localparam int SET_AW = 8;         // settings bus address width

   typedef struct packed {
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [31:0]       data;
   } set_bus_t;

   typedef enum logic [1:0] {SLV_MISC, SLV_READBACK, SLV_SETTINGS, SLV_NONE} wb_slave_e;

   // misc slave halfword offsets
   typedef enum logic [6:0] {
      REG_CGEN_CTRL = 7'd4,
      REG_CGEN_ST   = 7'd6,
      REG_TEST      = 7'd8
   } misc_reg_e;

   // settings addresses, time64 uses +0 high and +1 low
   localparam logic [SET_AW-1:0] SR_TIME64       = 8'd42;
   localparam logic [SET_AW-1:0] SR_REG_TEST32   = 8'd60;
   localparam logic [SET_AW-1:0] SR_GLOBAL_RESET = 8'd63;

   typedef enum logic [3:0] {
      RB_TIME_HI = 4'd0,
      RB_TIME_LO = 4'd1,
      RB_PPS_HI  = 4'd2,
      RB_PPS_LO  = 4'd3,
      RB_TEST32  = 4'd4,
      RB_COMPAT  = 4'd6
   } rb_word_e;

   localparam logic [31:0] COMPAT_NUM    = {16'd8, 16'd1};  // major, minor
   localparam logic [15:0] CGEN_CTRL_RST = 16'h0003;
   localparam logic [15:0] MISC_DEFAULT  = 16'hBEEF;
   localparam int          CORE_RST_CYCLES = 2;

endpackage

//--- wb_slave_decode.sv
/*
 * single master address decoder
 * gates stb to the selected slave and returns its response
 */
`timescale 1ns/1ps

module wb_slave_decode import u1plus_ctrl_pkg::*; (
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o,
   output wb_req_t misc_req_o,
   output wb_req_t rb_req_o,
   output wb_req_t set_req_o,
   input  wb_rsp_t misc_rsp_i,
   input  wb_rsp_t rb_rsp_i,
   input  wb_rsp_t set_rsp_i
);

   wb_slave_e slv_sel;

   // slave select from the top four address bits
   always_comb
   begin
      if (wb_req_i.adr[10:7] == 4'd0)
         slv_sel = SLV_MISC;
      else if (wb_req_i.adr[10:7] == 4'd7)
         slv_sel = SLV_READBACK;
      else if (wb_req_i.adr[10])
         slv_sel = SLV_SETTINGS;    // settings span eight slots
      else
         slv_sel = SLV_NONE;
   end

   always_comb
   begin
      misc_req_o     = wb_req_i;
      rb_req_o       = wb_req_i;
      set_req_o      = wb_req_i;
      misc_req_o.stb = wb_req_i.stb & (slv_sel == SLV_MISC);
      rb_req_o.stb   = wb_req_i.stb & (slv_sel == SLV_READBACK);
      set_req_o.stb  = wb_req_i.stb & (slv_sel == SLV_SETTINGS);
   end

   always_comb
   begin
      case (slv_sel)
         SLV_MISC     : wb_rsp_o = misc_rsp_i;
         SLV_READBACK : wb_rsp_o = rb_rsp_i;
         SLV_SETTINGS : wb_rsp_o = set_rsp_i;
         default      : wb_rsp_o = '0;       // unmapped, never acked
      endcase
   end

endmodule

//--- misc_regs.sv
/*
 * misc register slave
 * clock generator control word, test register and status readback
 */
`timescale 1ns/1ps

module misc_regs import u1plus_ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       core_rst_i,
   input  wb_req_t    req_i,
   output wb_rsp_t    rsp_o,
   input  logic [2:0] cgen_st_i,      // status, lock, refmon
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o
);

   logic        rst;
   logic [15:0] cgen_ctrl;
   logic [15:0] reg_test;
   misc_reg_e   reg_sel;

   assign rst     = wb_rst | core_rst_i;
   assign reg_sel = misc_reg_e'(req_i.adr[6:0]);

   always_ff @(posedge wb_clk)
   begin
      if (rst)
      begin
         cgen_ctrl <= CGEN_CTRL_RST;
         reg_test  <= '0;
      end
      else if (req_i.cyc & req_i.stb & req_i.we)
      begin
         case (reg_sel)
            REG_CGEN_CTRL : cgen_ctrl <= req_i.dat;
            REG_TEST      : reg_test  <= req_i.dat;
            default       : ;                     // status is read only
         endcase
      end
   end

   assign cgen_sync_b_o  = cgen_ctrl[1];
   assign cgen_ref_sel_o = cgen_ctrl[0];

   always_comb
   begin
      case (reg_sel)
         REG_CGEN_CTRL : rsp_o.dat = cgen_ctrl;
         REG_CGEN_ST   : rsp_o.dat = {13'd0, cgen_st_i};
         REG_TEST      : rsp_o.dat = reg_test;
         default       : rsp_o.dat = MISC_DEFAULT;
      endcase
   end

   assign rsp_o.ack = req_i.stb & req_i.cyc;  // zero wait state

endmodule

//--- settings_bus_16le.sv
/*
 * 16-bit little endian settings bus
 * low halfword is held, high halfword write issues the 32-bit strobe
 */
`timescale 1ns/1ps

module settings_bus_16le import u1plus_ctrl_pkg::*; (
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     core_rst_i,
   input  wb_req_t  req_i,
   output wb_rsp_t  rsp_o,
   output set_bus_t set_o
);

   logic        rst;
   logic        wr;
   logic [15:0] data_lo;

   assign rst = wb_rst | core_rst_i;
   assign wr  = req_i.cyc & req_i.stb & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (rst)
      begin
         data_lo <= '0;
         set_o   <= '0;
      end
      else
      begin
         set_o.stb <= wr & req_i.adr[1];   // one pulse per high half write
         if (wr & ~req_i.adr[1])
            data_lo <= req_i.dat;
         if (wr & req_i.adr[1])
         begin
            set_o.addr <= req_i.adr[9:2];
            set_o.data <= {req_i.dat, data_lo};
         end
      end
   end

   assign rsp_o.dat = '0;                  // write only
   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

//--- core_settings.sv
/*
 * core settings registers
 * 32-bit test setting and the global reset pulse generator
 */
`timescale 1ns/1ps

module core_settings import u1plus_ctrl_pkg::*; (
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  set_bus_t    set_i,
   output logic [31:0] reg_test32_o,
   output logic        core_rst_o
);

   logic [$clog2(CORE_RST_CYCLES+1)-1:0] rst_cnt;

   // test setting survives a global reset
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32_o <= '0;
      else if (set_i.stb && set_i.addr == SR_REG_TEST32)
         reg_test32_o <= set_i.data;
   end

   //////////////////////////////////////////////////
   // global reset, held for CORE_RST_CYCLES
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         rst_cnt <= '0;
      else if (set_i.stb && set_i.addr == SR_GLOBAL_RESET)
         rst_cnt <= CORE_RST_CYCLES[$bits(rst_cnt)-1:0];
      else if (rst_cnt != '0)
         rst_cnt <= rst_cnt - 1'b1;
   end

   assign core_rst_o = (rst_cnt != '0);

endmodule

//--- vita_time_64.sv
/*
 * 64-bit VITA time counter
 * free running tick count, loadable over settings, latched on PPS
 */
`timescale 1ns/1ps

module vita_time_64 import u1plus_ctrl_pkg::*; (
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic        core_rst_i,
   input  set_bus_t    set_i,
   input  logic        pps_i,
   output logic [63:0] vita_time_o,
   output logic [63:0] vita_time_pps_o
);

   logic        rst;
   logic [31:0] time_hi;      // high word waits for the low word
   logic [1:0]  pps_sync;
   logic        pps_d;
   logic        pps_edge;
   logic        load_hi;
   logic        load_lo;

   assign rst     = wb_rst | core_rst_i;
   assign load_hi = set_i.stb && (set_i.addr == SR_TIME64);
   assign load_lo = set_i.stb && (set_i.addr == SR_TIME64 + SET_AW'(1));

   //////////////////////////////////////////////////
   // tick counter
   always_ff @(posedge wb_clk)
   begin
      if (rst)
      begin
         time_hi     <= '0;
         vita_time_o <= '0;
      end
      else
      begin
         if (load_hi)
            time_hi <= set_i.data;
         if (load_lo)
            vita_time_o <= {time_hi, set_i.data};
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

   //////////////////////////////////////////////////
   // pps synchronizer and latch
   assign pps_edge = pps_sync[1] & ~pps_d;   // rising edge only

   always_ff @(posedge wb_clk)
   begin
      if (rst)
      begin
         pps_sync        <= '0;
         pps_d           <= 1'b0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

//--- readback_mux_16le.sv
/*
 * 32-bit readback mux read as 16-bit halves
 * data and ack are registered, one ack per access
 */
`timescale 1ns/1ps

module readback_mux_16le import u1plus_ctrl_pkg::*; (
   input  logic        wb_clk,
   input  logic        wb_rst,
   input  logic        core_rst_i,
   input  wb_req_t     req_i,
   output wb_rsp_t     rsp_o,
   input  logic [63:0] vita_time_i,
   input  logic [63:0] vita_time_pps_i,
   input  logic [31:0] reg_test32_i
);

   logic        rst;
   rb_word_e    word_sel;
   logic [31:0] word;

   assign rst      = wb_rst | core_rst_i;
   assign word_sel = rb_word_e'(req_i.adr[5:2]);

   always_comb
   begin
      case (word_sel)
         RB_TIME_HI : word = vita_time_i[63:32];
         RB_TIME_LO : word = vita_time_i[31:0];
         RB_PPS_HI  : word = vita_time_pps_i[63:32];
         RB_PPS_LO  : word = vita_time_pps_i[31:0];
         RB_TEST32  : word = reg_test32_i;
         RB_COMPAT  : word = COMPAT_NUM;
         default    : word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst)
         rsp_o <= '0;
      else
      begin
         rsp_o.ack <= req_i.cyc & req_i.stb & ~rsp_o.ack;  // drop after one cycle
         rsp_o.dat <= req_i.adr[1] ? word[31:16] : word[15:0];
      end
   end

endmodule

//--- u1plus_ctrl_top.sv
/*
 * u1plus control plane top level
 * decoder, misc registers, settings bus, readback mux and VITA time
 */
`timescale 1ns/1ps

module u1plus_ctrl_top import u1plus_ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_req_t    wb_req_i,
   output wb_rsp_t    wb_rsp_o,
   input  logic [2:0] cgen_st_i,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o,
   input  logic       pps_i
);

   wb_req_t     misc_req, rb_req, set_req;
   wb_rsp_t     misc_rsp, rb_rsp, set_rsp;
   set_bus_t    set_bus;
   logic        core_rst;
   logic [63:0] vita_time, vita_time_pps;
   logic [31:0] reg_test32;

   wb_slave_decode i_wb_slave_decode (
      .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
      .misc_req_o(misc_req), .rb_req_o(rb_req), .set_req_o(set_req),
      .misc_rsp_i(misc_rsp), .rb_rsp_i(rb_rsp), .set_rsp_i(set_rsp));

   misc_regs i_misc_regs (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .core_rst_i(core_rst),
      .req_i(misc_req), .rsp_o(misc_rsp), .cgen_st_i(cgen_st_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bus_16le i_settings_bus_16le (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .core_rst_i(core_rst),
      .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus));

   core_settings i_core_settings (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .reg_test32_o(reg_test32), .core_rst_o(core_rst));

   vita_time_64 i_vita_time_64 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .core_rst_i(core_rst),
      .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   readback_mux_16le i_readback_mux_16le (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .core_rst_i(core_rst),
      .req_i(rb_req), .rsp_o(rb_rsp),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .reg_test32_i(reg_test32));

endmodule

//--- u1plus_ctrl_asserts.sv
/*
 * bound checks on the control plane
 * ack follows stb, one cycle settings strobe, fixed core reset width
 */
`timescale 1ns/1ps

module u1plus_ctrl_asserts import u1plus_ctrl_pkg::*; (
   input logic    wb_clk,
   input logic    wb_rst,
   input wb_req_t req_i,
   input wb_rsp_t rsp_i,
   input logic    set_stb_i,
   input logic    core_rst_i
);

   int fail_cnt = 0;   // summed into the end of run totals

   ack_needs_stb : assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(rsp_i.ack) |-> req_i.stb)
      else
      begin
         fail_cnt++;
         $error("ack rose without stb");
      end

   set_stb_pulse : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_i |=> !set_stb_i)
      else
      begin
         fail_cnt++;
         $error("settings strobe longer than one cycle");
      end

   core_rst_width : assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(core_rst_i) |-> core_rst_i [*CORE_RST_CYCLES] ##1 !core_rst_i)
      else
      begin
         fail_cnt++;
         $error("core reset pulse has the wrong width");
      end

endmodule

bind u1plus_ctrl_top u1plus_ctrl_asserts i_u1plus_ctrl_asserts (
   .wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(wb_req_i), .rsp_i(wb_rsp_o),
   .set_stb_i(set_bus.stb), .core_rst_i(core_rst));

//--- tb_u1plus_ctrl.sv
/*
 * testbench for the u1plus control plane
 * table driven bus accesses, then VITA time, PPS and global reset checks
 */
`timescale 1ns/1ps

module tb_u1plus_ctrl import u1plus_ctrl_pkg::*; ();

   localparam int ACK_TIMEOUT = 20;   // cycles

   typedef enum {OP_WR, OP_RD, OP_SET, OP_PINS} op_e;

   typedef struct {
      string       name;
      op_e         op;
      logic [10:0] adr;
      logic [31:0] data;
      logic [31:0] exp;
   } step_t;

   logic       wb_clk = 1'b0;
   logic       wb_rst;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic [2:0] cgen_st;
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   logic       pps;
   step_t      steps[$];
   int         errors = 0;
   int         checks = 0;

   always #20 wb_clk = ~wb_clk;

   u1plus_ctrl_top i_u1plus_ctrl_top (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st), .cgen_sync_b_o(cgen_sync_b),
      .cgen_ref_sel_o(cgen_ref_sel), .pps_i(pps));

   //////////////////////////////////////////////////
   // address helpers
   function automatic logic [10:0] sr_adr(logic [7:0] sr);
      return {1'b1, sr, 2'b00};                  // low half, adr[1] = 0
   endfunction

   function automatic logic [10:0] rb_adr(logic [3:0] word, logic half);
      return {4'd7, 1'b0, word, half, 1'b0};
   endfunction

   function automatic void add_step(string name, op_e op, logic [10:0] adr,
                                    logic [31:0] data, logic [31:0] exp);
      step_t s;
      s.name = name;
      s.op   = op;
      s.adr  = adr;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
   endfunction

   task automatic value_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
   endtask

   task automatic out_of_range(input string name, input string expect_txt,
                               input logic [31:0] act);
      errors++;
      $display("CHECK FAILED %s: expected %s, actual %0d", name, expect_txt, act);
   endtask

   //////////////////////////////////////////////////
   // bus master, entered and left 2 ns after a rising edge
   task automatic bus_cycle(input logic [10:0] adr, input logic we,
                            input logic [15:0] dat, output logic [15:0] rdat);
      int waited;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      waited     = 0;
      @(negedge wb_clk);
      while (!wb_rsp.ack && waited < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      if (!wb_rsp.ack)
      begin
         errors++;
         $display("no ack from address %h within %0d cycles", adr, ACK_TIMEOUT);
      end
      rdat = wb_rsp.dat;
      @(posedge wb_clk);
      #2;
      wb_req = '0;                               // stb drops the cycle after ack
   endtask

   task automatic wb_write(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_cycle(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input logic [10:0] adr, output logic [15:0] dat);
      bus_cycle(adr, 1'b0, 16'h0000, dat);
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge wb_clk);
      #2;
   endtask

   // low half first, the high half fires the strobe
   task automatic set_write(input logic [10:0] adr, input logic [31:0] data);
      wb_write(adr, data[15:0]);
      wb_write(adr | 11'h002, data[31:16]);
      idle(4);                                   // strobe, then core reset if any
   endtask

   task automatic run_steps();
      step_t       s;
      logic [15:0] rdat;
      while (steps.size() > 0)
      begin
         s = steps.pop_front();
         case (s.op)
            OP_WR  : wb_write(s.adr, s.data[15:0]);
            OP_SET : set_write(s.adr, s.data);
            OP_RD  :
            begin
               wb_read(s.adr, rdat);
               checks++;
               if (rdat !== s.exp[15:0])
                  value_mismatch(s.name, s.exp, {16'h0000, rdat});
            end
            OP_PINS :
            begin
               checks++;
               if ({cgen_sync_b, cgen_ref_sel} !== s.exp[1:0])
                  value_mismatch(s.name, s.exp, {30'd0, cgen_sync_b, cgen_ref_sel});
            end
         endcase
      end
   endtask

   //////////////////////////////////////////////////
   initial
   begin
      logic [15:0] r_test;
      logic [15:0] r_cgen;
      logic [31:0] r_t32;
      logic [15:0] lo;
      logic [15:0] hi;
      logic [15:0] t_a;
      logic [15:0] t_b;
      logic [15:0] t_pps;
      int          afails;

      void'($urandom(78923));
      wb_rst  = 1'b1;
      wb_req  = '0;
      cgen_st = 3'b101;
      pps     = 1'b0;
      r_test  = 16'($urandom) | 16'h0100;        // never the reset value
      r_cgen  = (16'($urandom) & 16'hFFFC) | 16'h0001;  // sync_b low, ref_sel high
      r_t32   = $urandom | 32'h1;
      repeat (3) @(posedge wb_clk);
      #2;
      wb_rst = 1'b0;

      add_step("rst_cgen_ctrl", OP_RD,   11'(REG_CGEN_CTRL), 0, 32'h0003);
      add_step("rst_cgen_pins", OP_PINS, 11'd0, 0, 32'h3);
      add_step("rst_test_reg",  OP_RD,   11'(REG_TEST), 0, 32'h0000);
      add_step("undef_offset",  OP_RD,   11'd2, 0, 32'hBEEF);
      add_step("cgen_status",   OP_RD,   11'(REG_CGEN_ST), 0, 32'h0005);
      add_step("test_reg_wr",   OP_WR,   11'(REG_TEST), r_test, 0);
      add_step("test_reg_rd",   OP_RD,   11'(REG_TEST), 0, r_test);
      add_step("cgen_ctrl_wr",  OP_WR,   11'(REG_CGEN_CTRL), r_cgen, 0);
      add_step("cgen_ctrl_rd",  OP_RD,   11'(REG_CGEN_CTRL), 0, r_cgen);
      add_step("cgen_pins",     OP_PINS, 11'd0, 0, {30'd0, r_cgen[1:0]});
      add_step("test32_set",    OP_SET,  sr_adr(SR_REG_TEST32), r_t32, 0);
      add_step("test32_lo",     OP_RD,   rb_adr(RB_TEST32, 1'b0), 0, r_t32[15:0]);
      add_step("test32_hi",     OP_RD,   rb_adr(RB_TEST32, 1'b1), 0, r_t32[31:16]);
      add_step("compat_lo",     OP_RD,   rb_adr(RB_COMPAT, 1'b0), 0, 32'h0001);
      add_step("compat_hi",     OP_RD,   rb_adr(RB_COMPAT, 1'b1), 0, 32'h0008);
      add_step("word5_lo",      OP_RD,   rb_adr(4'd5, 1'b0), 0, 32'h0000);
      run_steps();

      // time load, then count
      set_write(sr_adr(SR_TIME64), 32'd5);
      set_write(sr_adr(SR_TIME64 + 8'd1), 32'd100);
      wb_read(rb_adr(RB_TIME_HI, 1'b0), lo);
      wb_read(rb_adr(RB_TIME_HI, 1'b1), hi);
      checks++;
      if ({hi, lo} !== 32'd5)
         value_mismatch("time_hi", 32'd5, {hi, lo});
      wb_read(rb_adr(RB_TIME_LO, 1'b0), t_a);
      wb_read(rb_adr(RB_TIME_LO, 1'b0), t_b);
      checks += 2;
      if (t_a <= 16'd100 || t_a >= 16'd300)
         out_of_range("time_load_lo", "between 100 and 300", t_a);
      if (t_b <= t_a)
         out_of_range("time_advance", $sformatf("above %0d", t_a), t_b);

      // PPS latch must land between two time reads
      wb_read(rb_adr(RB_TIME_LO, 1'b0), t_a);
      pps = 1'b1;
      idle(4);
      pps = 1'b0;
      idle(10);
      wb_read(rb_adr(RB_TIME_LO, 1'b0), t_b);
      wb_read(rb_adr(RB_PPS_LO, 1'b0), t_pps);
      wb_read(rb_adr(RB_PPS_HI, 1'b0), hi);
      checks += 2;
      if (t_pps <= t_a || t_pps >= t_b)
         out_of_range("pps_lo", $sformatf("between %0d and %0d", t_a, t_b), t_pps);
      if (hi !== 16'd5)
         value_mismatch("pps_hi", 32'd5, {16'h0000, hi});

      // global reset clears the core but keeps the test setting
      add_step("glob_rst",       OP_SET,  sr_adr(SR_GLOBAL_RESET), 32'h1, 0);
      add_step("test_reg_clr",   OP_RD,   11'(REG_TEST), 0, 32'h0000);
      add_step("cgen_ctrl_clr",  OP_RD,   11'(REG_CGEN_CTRL), 0, 32'h0003);
      add_step("cgen_pins_clr",  OP_PINS, 11'd0, 0, 32'h3);
      add_step("test32_kept_lo", OP_RD,   rb_adr(RB_TEST32, 1'b0), 0, r_t32[15:0]);
      add_step("test32_kept_hi", OP_RD,   rb_adr(RB_TEST32, 1'b1), 0, r_t32[31:16]);
      run_steps();
      wb_read(rb_adr(RB_TIME_LO, 1'b0), t_a);
      wb_read(rb_adr(RB_TIME_HI, 1'b0), hi);
      checks += 2;
      if (t_a >= 16'd100)
         out_of_range("time_after_rst", "below 100", t_a);
      if (hi !== 16'd0)
         value_mismatch("time_hi_after_rst", 32'd0, {16'h0000, hi});

      afails = i_u1plus_ctrl_top.i_u1plus_ctrl_asserts.fail_cnt;
      $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, afails);
      if (errors + afails == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- u1plus_ctrl.f
u1plus_ctrl_pkg.sv
wb_slave_decode.sv
misc_regs.sv
settings_bus_16le.sv
core_settings.sv
vita_time_64.sv
readback_mux_16le.sv
u1plus_ctrl_top.sv
u1plus_ctrl_asserts.sv
tb_u1plus_ctrl.sv

//--- Bender.yml
package:
  name: u1plus_ctrl

sources:
  - u1plus_ctrl_pkg.sv
  - wb_slave_decode.sv
  - misc_regs.sv
  - settings_bus_16le.sv
  - core_settings.sv
  - vita_time_64.sv
  - readback_mux_16le.sv
  - u1plus_ctrl_top.sv
  - target: simulation
    files:
      - u1plus_ctrl_asserts.sv
      - tb_u1plus_ctrl.sv
